// File: hdl/lockstep_compare.sv
// cycle-by-cycle comparison of two core traces, latches the first divergence and its class
`timescale 1ns/1ps

module lockstep_compare (
    input  logic                          clk,
    input  logic                          arst_n,
    input  lockstep_pkg::core_trace_t     trace_a,
    input  lockstep_pkg::core_trace_t     trace_b,
    output logic                          diverge,
    output lockstep_pkg::diverge_cause_t  diverge_cause
);

    logic pc_diff;
    logic inst_diff;
    logic wb_diff;
    logic st_diff;
    lockstep_pkg::diverge_cause_t cause_now;

    assign pc_diff   = (trace_a.if_pc != trace_b.if_pc) || (trace_a.ex_pc != trace_b.ex_pc);
    assign inst_diff = trace_a.ex_inst != trace_b.ex_inst;

    // payload only counts when the write happens
    assign wb_diff = (trace_a.wb_valid != trace_b.wb_valid) ||
                     (trace_a.wb_valid && ((trace_a.wb_rd != trace_b.wb_rd) ||
                                           (trace_a.wb_data != trace_b.wb_data)));
    assign st_diff = (trace_a.st_valid != trace_b.st_valid) ||
                     (trace_a.st_valid && ((trace_a.st_addr != trace_b.st_addr) ||
                                           (trace_a.st_data != trace_b.st_data)));

    // pc > inst > wb > store
    always_comb begin
        if (pc_diff) begin
            cause_now = lockstep_pkg::cause_pc;
        end else if (inst_diff) begin
            cause_now = lockstep_pkg::cause_inst;
        end else if (wb_diff) begin
            cause_now = lockstep_pkg::cause_wb;
        end else if (st_diff) begin
            cause_now = lockstep_pkg::cause_store;
        end else begin
            cause_now = lockstep_pkg::cause_none;
        end
    end

    // sticky, only the first mismatch is recorded
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            diverge       <= 1'b0;
            diverge_cause <= lockstep_pkg::cause_none;
        end else if (!diverge && cause_now != lockstep_pkg::cause_none) begin
            diverge       <= 1'b1;
            diverge_cause <= cause_now;
        end
    end

endmodule

// File: hdl/lockstep_pkg.sv
// lockstep harness sizes, per-cycle core trace and divergence classes shared by RTL and testbench
package lockstep_pkg;

    localparam int prog_depth = 16;
    localparam int prog_aw    = 4;   // program word index
    localparam int dmem_depth = 16;
    localparam int dmem_aw    = 4;   // word index taken from address bits 5..2

    // observable state of one core in one cycle
    typedef struct packed {
        logic [rv_isa_pkg::xlen-1:0] if_pc;
        logic [rv_isa_pkg::xlen-1:0] ex_pc;
        logic [rv_isa_pkg::xlen-1:0] ex_inst;
        logic                        wb_valid;  // register file write this cycle
        logic [4:0]                  wb_rd;
        logic [rv_isa_pkg::xlen-1:0] wb_data;
        logic                        st_valid;
        logic [rv_isa_pkg::xlen-1:0] st_addr;
        logic [rv_isa_pkg::xlen-1:0] st_data;
    } core_trace_t;

    // listed in compare priority order after none
    typedef enum logic [2:0] {
        cause_none  = 3'd0,
        cause_pc    = 3'd1,
        cause_inst  = 3'd2,
        cause_wb    = 3'd3,
        cause_store = 3'd4
    } diverge_cause_t;

endpackage

// File: hdl/lockstep_top.sv
// dual-core lockstep subsystem: shared program memory, two core copies and the trace comparator
`timescale 1ns/1ps

module lockstep_top (
    input  logic                               clk,
    input  logic                               arst_n,
    input  logic                               prog_we,
    input  logic [lockstep_pkg::prog_aw-1:0]   prog_addr,
    input  logic [rv_isa_pkg::xlen-1:0]        prog_data,
    input  logic                               run,
    input  logic                               inject_err,
    input  logic [4:0]                         inject_reg,
    output logic                               st_valid,
    output logic [rv_isa_pkg::xlen-1:0]        st_addr,
    output logic [rv_isa_pkg::xlen-1:0]        st_data,
    output logic                               halted,
    output logic                               diverge,
    output lockstep_pkg::diverge_cause_t       diverge_cause
);

    logic [lockstep_pkg::prog_aw-1:0] fetch_addr0;
    logic [lockstep_pkg::prog_aw-1:0] fetch_addr1;
    logic [rv_isa_pkg::xlen-1:0]      fetch_inst0;
    logic [rv_isa_pkg::xlen-1:0]      fetch_inst1;
    lockstep_pkg::core_trace_t        trace0;
    lockstep_pkg::core_trace_t        trace1;

    program_mem pmem_i (
        .clk     (clk),
        .we      (prog_we && !run),  // loading only while idle
        .waddr   (prog_addr),
        .wdata   (prog_data),
        .raddr_a (fetch_addr0),
        .raddr_b (fetch_addr1),
        .rdata_a (fetch_inst0),
        .rdata_b (fetch_inst1)
    );

    rv_core core0_i (
        .clk        (clk),
        .arst_n     (arst_n),
        .run        (run),
        .fetch_inst (fetch_inst0),
        .inject_err (1'b0),  // reference copy never faulted
        .inject_reg (5'd0),
        .fetch_addr (fetch_addr0),
        .halted     (halted),
        .trace      (trace0)
    );

    rv_core core1_i (
        .clk        (clk),
        .arst_n     (arst_n),
        .run        (run),
        .fetch_inst (fetch_inst1),
        .inject_err (inject_err),
        .inject_reg (inject_reg),
        .fetch_addr (fetch_addr1),
        .halted     (),
        .trace      (trace1)
    );

    lockstep_compare cmp_i (
        .clk           (clk),
        .arst_n        (arst_n),
        .trace_a       (trace0),
        .trace_b       (trace1),
        .diverge       (diverge),
        .diverge_cause (diverge_cause)
    );

    // store stream seen from core 0
    assign st_valid = trace0.st_valid;
    assign st_addr  = trace0.st_addr;
    assign st_data  = trace0.st_data;

endmodule

// File: hdl/program_mem.sv
// shared program image, written by the loader while idle and read by both cores each cycle
`timescale 1ns/1ps

module program_mem (
    input  logic                               clk,
    input  logic                               we,
    input  logic [lockstep_pkg::prog_aw-1:0]   waddr,
    input  logic [rv_isa_pkg::xlen-1:0]        wdata,
    input  logic [lockstep_pkg::prog_aw-1:0]   raddr_a,
    input  logic [lockstep_pkg::prog_aw-1:0]   raddr_b,
    output logic [rv_isa_pkg::xlen-1:0]        rdata_a,
    output logic [rv_isa_pkg::xlen-1:0]        rdata_b
);

    // image is kept across reset
    logic [rv_isa_pkg::xlen-1:0] mem [lockstep_pkg::prog_depth];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    // async reads, one port per core copy
    assign rdata_a = mem[raddr_a];
    assign rdata_b = mem[raddr_b];

endmodule

// File: hdl/rv_core.sv
// three-stage RV32I subset core (addi/add/lw/sw) with local data memory, instantiated twice in lockstep
`timescale 1ns/1ps

module rv_core (
    input  logic                               clk,
    input  logic                               arst_n,
    input  logic                               run,
    input  logic [rv_isa_pkg::xlen-1:0]        fetch_inst,
    input  logic                               inject_err,
    input  logic [4:0]                         inject_reg,
    output logic [lockstep_pkg::prog_aw-1:0]   fetch_addr,
    output logic                               halted,
    output lockstep_pkg::core_trace_t          trace
);

    logic [lockstep_pkg::prog_aw:0]     pc_q;  // msb set once word 15 is fetched
    logic                               fetch_done;
    logic [rv_isa_pkg::xlen-1:0]        if_pc;

    logic                               ex_valid_q;
    logic [rv_isa_pkg::xlen-1:0]        ex_inst_q;
    logic [rv_isa_pkg::xlen-1:0]        ex_pc_q;
    rv_isa_pkg::inst_fields_t           ex_fields;
    rv_isa_pkg::decoded_t               ex_dec;
    logic [rv_isa_pkg::xlen-1:0]        rs1_val;
    logic [rv_isa_pkg::xlen-1:0]        rs2_val;
    logic [rv_isa_pkg::xlen-1:0]        alu_out;

    rv_isa_pkg::decoded_t               wb_dec_q;
    logic [rv_isa_pkg::xlen-1:0]        wb_alu_q;      // result or memory address
    logic [rv_isa_pkg::xlen-1:0]        wb_st_data_q;
    logic [rv_isa_pkg::xlen-1:0]        wb_load_data;
    logic [rv_isa_pkg::xlen-1:0]        wb_data;
    logic                               wb_we;
    logic                               wb_st;
    logic [lockstep_pkg::dmem_aw-1:0]   dmem_idx;

    logic [rv_isa_pkg::xlen-1:0] rf   [rv_isa_pkg::nregs];
    logic [rv_isa_pkg::xlen-1:0] dmem [lockstep_pkg::dmem_depth];

    assign fetch_done = pc_q[lockstep_pkg::prog_aw];
    assign fetch_addr = pc_q[lockstep_pkg::prog_aw-1:0];
    assign if_pc      = {{(rv_isa_pkg::xlen - lockstep_pkg::prog_aw - 2){1'b0}},
                         fetch_addr, 2'b00};

    // fetch, one word per cycle while run is high
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc_q       <= '0;
            ex_valid_q <= 1'b0;
            ex_inst_q  <= rv_isa_pkg::nop_inst;
            ex_pc_q    <= '0;
        end else if (run && !fetch_done) begin
            pc_q       <= pc_q + 1'b1;
            ex_valid_q <= 1'b1;
            ex_inst_q  <= fetch_inst;
            ex_pc_q    <= if_pc;
        end else begin
            ex_valid_q <= 1'b0;  // bubble
            ex_inst_q  <= rv_isa_pkg::nop_inst;
        end
    end

    // set when word 15 has left execute, i.e. it is in writeback now
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            halted <= 1'b0;
        end else if (fetch_done && !ex_valid_q) begin
            halted <= 1'b1;
        end
    end

    // decode, anything unrecognised leaves all flags clear and acts as nop
    always_comb begin
        ex_fields      = ex_inst_q;
        ex_dec         = '0;
        ex_dec.rd      = ex_fields.rd;
        ex_dec.rs1     = ex_fields.rs1;
        ex_dec.rs2     = ex_fields.rs2;
        ex_dec.is_alu_imm = (ex_fields.opcode == rv_isa_pkg::opc_op_imm) &&
                            (ex_fields.funct3 == rv_isa_pkg::f3_add);
        ex_dec.is_alu_reg = (ex_fields.opcode == rv_isa_pkg::opc_op) &&
                            (ex_fields.funct3 == rv_isa_pkg::f3_add) &&
                            (ex_fields.funct7 == rv_isa_pkg::f7_add);
        ex_dec.is_load    = (ex_fields.opcode == rv_isa_pkg::opc_load) &&
                            (ex_fields.funct3 == rv_isa_pkg::f3_word);
        ex_dec.is_store   = (ex_fields.opcode == rv_isa_pkg::opc_store) &&
                            (ex_fields.funct3 == rv_isa_pkg::f3_word);
        if (ex_dec.is_store) begin
            ex_dec.imm = {{(rv_isa_pkg::xlen - 12){ex_fields.funct7[6]}},
                          ex_fields.funct7, ex_fields.rd};
        end else begin
            ex_dec.imm = {{(rv_isa_pkg::xlen - 12){ex_fields.funct7[6]}},
                          ex_fields.funct7, ex_fields.rs2};
        end
        ex_dec.writes_rd = (ex_dec.is_alu_imm || ex_dec.is_alu_reg || ex_dec.is_load) &&
                           (ex_fields.rd != 5'd0);
    end

    // forwarding from writeback, wb_we is never set for x0
    assign rs1_val = (wb_we && wb_dec_q.rd == ex_dec.rs1) ? wb_data : rf[ex_dec.rs1];
    assign rs2_val = (wb_we && wb_dec_q.rd == ex_dec.rs2) ? wb_data : rf[ex_dec.rs2];

    // add for all four ops, rs2 only on add
    assign alu_out = rs1_val + (ex_dec.is_alu_reg ? rs2_val : ex_dec.imm);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wb_dec_q <= '0;
        end else begin
            wb_dec_q <= ex_dec;
        end
    end

    always_ff @(posedge clk) begin
        wb_alu_q     <= alu_out;
        wb_st_data_q <= rs2_val;
    end

    // memory / writeback
    assign wb_we        = wb_dec_q.writes_rd;
    assign wb_st        = wb_dec_q.is_store;
    assign dmem_idx     = wb_alu_q[lockstep_pkg::dmem_aw+1:2];
    assign wb_load_data = dmem[dmem_idx];  // comb read, no stall on load use
    assign wb_data      = wb_dec_q.is_load ? wb_load_data : wb_alu_q;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < lockstep_pkg::dmem_depth; i++) begin
                dmem[i] <= '0;
            end
        end else if (wb_st) begin
            dmem[dmem_idx] <= wb_st_data_q;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < rv_isa_pkg::nregs; i++) begin
                rf[i] <= '0;
            end
        end else begin
            if (wb_we) begin
                rf[wb_dec_q.rd] <= wb_data;
            end
            // self-test fault, x0 stays hardwired
            if (inject_err && inject_reg != 5'd0) begin
                rf[inject_reg] <= rf[inject_reg] ^ {{(rv_isa_pkg::xlen - 1){1'b0}}, 1'b1};
            end
        end
    end

    always_comb begin
        trace          = '0;
        trace.if_pc    = if_pc;
        trace.ex_pc    = ex_pc_q;
        trace.ex_inst  = ex_inst_q;
        trace.wb_valid = wb_we;
        trace.wb_rd    = wb_dec_q.rd;
        trace.wb_data  = wb_data;
        trace.st_valid = wb_st;
        trace.st_addr  = wb_alu_q;
        trace.st_data  = wb_st_data_q;
    end

endmodule

// File: hdl/rv_isa_pkg.sv
// RV32I subset encodings and decoded-instruction type, referenced by the cores and the testbench
package rv_isa_pkg;

    localparam int xlen  = 32;  // data and address width
    localparam int nregs = 32;  // architectural registers incl. x0

    // major opcodes
    localparam logic [6:0] opc_op_imm = 7'b0010011;
    localparam logic [6:0] opc_op     = 7'b0110011;
    localparam logic [6:0] opc_load   = 7'b0000011;
    localparam logic [6:0] opc_store  = 7'b0100011;

    localparam logic [2:0] f3_add  = 3'b000;  // addi / add
    localparam logic [2:0] f3_word = 3'b010;  // lw / sw
    localparam logic [6:0] f7_add  = 7'b0000000;

    localparam logic [xlen-1:0] nop_inst = 32'h0000_0013;  // addi x0, x0, 0

    // raw instruction word split into its fields, R-type layout
    typedef struct packed {
        logic [6:0] funct7;  // imm[11:5] for I and S
        logic [4:0] rs2;     // imm[4:0] for I
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;      // imm[4:0] for S
        logic [6:0] opcode;
    } inst_fields_t;

    typedef struct packed {
        logic [4:0]      rd;
        logic [4:0]      rs1;
        logic [4:0]      rs2;
        logic [xlen-1:0] imm;        // sign extended, I or S form
        logic            is_alu_imm;
        logic            is_alu_reg;
        logic            is_load;
        logic            is_store;
        logic            writes_rd;  // never set for x0
    } decoded_t;

endpackage

// File: project.f
hdl/rv_isa_pkg.sv
hdl/lockstep_pkg.sv
hdl/program_mem.sv
hdl/rv_core.sv
hdl/lockstep_compare.sv
hdl/lockstep_top.sv
tb/lockstep_sva.sv
tb/lockstep_checker.sv
tb/lockstep_tb.sv

// File: run.sh
#!/bin/sh
# build the lockstep testbench with Verilator, run it and look for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module lockstep_tb \
    -f project.f -o lockstep_sim \
    && ./obj_dir/lockstep_sim | tee /dev/stderr | grep -qF "Test completed successfully" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

// File: tb/lockstep_checker.sv
// watches the lockstep ports, compares the store stream and the flags with what the testbench expects
`timescale 1ns/1ps

module lockstep_checker (
    input logic                          clk,
    input logic                          arst_n,
    input logic                          st_valid,
    input logic [31:0]                   st_addr,
    input logic [31:0]                   st_data,
    input logic                          halted,
    input logic                          diverge,
    input lockstep_pkg::diverge_cause_t  diverge_cause
);

    typedef struct packed {
        logic [31:0] addr;
        logic [31:0] data;
    } store_t;

    store_t expected_q [$];
    store_t exp_st;
    int     error_count  = 0;
    logic   halted_seen  = 1'b0;
    logic   diverge_seen = 1'b0;

    task automatic value_error(input string name, input logic [31:0] exp, input logic [31:0] obs);
        $display("** Error at %0t: %s expected %h observed %h", $time, name, exp, obs);
        error_count++;
    endtask

    task automatic plain_error(input string what);
        $display("at %0t: %s", $time, what);
        error_count++;
    endtask

    task automatic start_test();
        expected_q.delete();
        halted_seen  = 1'b0;
        diverge_seen = 1'b0;
    endtask

    task automatic expect_store(input logic [31:0] addr, input logic [31:0] data);
        expected_q.push_back({addr, data});
    endtask

    // outputs must sit at their reset values
    task automatic check_idle();
        if (st_valid !== 1'b0) value_error("st_valid", 32'd0, 32'(st_valid));
        if (halted !== 1'b0) value_error("halted", 32'd0, 32'(halted));
        if (diverge !== 1'b0) value_error("diverge", 32'd0, 32'(diverge));
        if (diverge_cause !== lockstep_pkg::cause_none) begin
            value_error("diverge_cause", 32'(lockstep_pkg::cause_none), 32'(diverge_cause));
        end
    endtask

    task automatic finish_test(input logic exp_div, input lockstep_pkg::diverge_cause_t exp_cause);
        if (expected_q.size() != 0) begin
            plain_error($sformatf("%0d expected stores never appeared", expected_q.size()));
        end
        if (!halted_seen) plain_error("halted never rose");
        if (exp_div) begin
            if (diverge !== 1'b1) value_error("diverge", 32'd1, 32'(diverge));
            if (diverge_cause !== exp_cause) begin
                value_error("diverge_cause", 32'(exp_cause), 32'(diverge_cause));
            end
        end else if (diverge_seen) begin
            plain_error("diverge rose although both cores ran the same program");
        end
    endtask

    // mid-cycle sampling, outputs settled
    always @(negedge clk) begin
        if (!arst_n) begin
            check_idle();
        end else begin
            if (halted) halted_seen = 1'b1;
            if (diverge) diverge_seen = 1'b1;
            if (st_valid && expected_q.size() == 0) begin
                plain_error("store seen with no store left in the expected list");
            end else if (st_valid) begin
                exp_st = expected_q.pop_front();
                if (st_addr !== exp_st.addr) value_error("st_addr", exp_st.addr, st_addr);
                if (st_data !== exp_st.data) value_error("st_data", exp_st.data, st_data);
            end
        end
    end

endmodule

// File: tb/lockstep_sva.sv
// comparator properties, attached to every lockstep_compare instance through bind
`timescale 1ns/1ps

module lockstep_sva (
    input logic                          clk,
    input logic                          arst_n,
    input lockstep_pkg::core_trace_t     trace_a,
    input lockstep_pkg::core_trace_t     trace_b,
    input logic                          diverge,
    input lockstep_pkg::diverge_cause_t  diverge_cause
);

    int fail_count = 0;  // read by the testbench at the end

    sticky_diverge: assert property (@(posedge clk) disable iff (!arst_n)
        diverge |=> diverge)
        else begin
            fail_count++;
            $error("diverge fell while reset was inactive");
        end

    // cause is none exactly while the flag is low
    cause_matches_flag: assert property (@(posedge clk) disable iff (!arst_n)
        (diverge_cause == lockstep_pkg::cause_none) == !diverge)
        else begin
            fail_count++;
            $error("diverge_cause disagrees with diverge");
        end

    equal_traces_no_flag: assert property (@(posedge clk) disable iff (!arst_n)
        (!diverge && trace_a == trace_b) |=> !diverge)
        else begin
            fail_count++;
            $error("diverge rose after a cycle with identical traces");
        end

endmodule

bind lockstep_compare lockstep_sva sva_i (
    .clk           (clk),
    .arst_n        (arst_n),
    .trace_a       (trace_a),
    .trace_b       (trace_b),
    .diverge       (diverge),
    .diverge_cause (diverge_cause)
);

// File: tb/lockstep_tb.sv
// lockstep harness testbench: loads programs, runs the five tests and predicts each store stream
`timescale 1ns/1ps

module lockstep_tb;

    localparam int clk_period    = 100;
    localparam int drive_delay   = 10;  // inputs change after the rising edge
    localparam int reset_cycles  = 5;
    localparam int n_tests       = 5;
    localparam int load_cycles   = 16;
    localparam int run_cycles    = 18;
    localparam int margin_cycles = 10;
    localparam int cycle_limit   = n_tests * (load_cycles + run_cycles + margin_cycles)
                                   + n_tests * reset_cycles;
    localparam logic [31:0] nop  = rv_isa_pkg::nop_inst;

    typedef struct packed {
        logic [31:0] addr;
        logic [31:0] data;
    } store_t;
    typedef store_t store_list_t [$];

    logic                               clk = 1'b0;  // low from the start, first edge is a rise
    logic                               arst_n;
    logic                               prog_we;
    logic [lockstep_pkg::prog_aw-1:0]   prog_addr;
    logic [31:0]                        prog_data;
    logic                               run;
    logic                               inject_err;
    logic [4:0]                         inject_reg;
    logic                               st_valid;
    logic [31:0]                        st_addr;
    logic [31:0]                        st_data;
    logic                               halted;
    logic                               diverge;
    lockstep_pkg::diverge_cause_t       diverge_cause;

    logic [31:0] prog [16];
    int cycle_count  = 0;
    int tests_passed = 0;
    int tests_failed = 0;
    int total_errors;

    lockstep_top dut_i (
        .clk           (clk),
        .arst_n        (arst_n),
        .prog_we       (prog_we),
        .prog_addr     (prog_addr),
        .prog_data     (prog_data),
        .run           (run),
        .inject_err    (inject_err),
        .inject_reg    (inject_reg),
        .st_valid      (st_valid),
        .st_addr       (st_addr),
        .st_data       (st_data),
        .halted        (halted),
        .diverge       (diverge),
        .diverge_cause (diverge_cause)
    );

    lockstep_checker checker_i (
        .clk           (clk),
        .arst_n        (arst_n),
        .st_valid      (st_valid),
        .st_addr       (st_addr),
        .st_data       (st_data),
        .halted        (halted),
        .diverge       (diverge),
        .diverge_cause (diverge_cause)
    );

    initial begin
        forever #(clk_period / 2) clk = ~clk;
    end

    // instruction encoders
    function automatic logic [31:0] addi(input int rd, input int rs1, input int imm);
        return {12'(imm), 5'(rs1), rv_isa_pkg::f3_add, 5'(rd), rv_isa_pkg::opc_op_imm};
    endfunction

    function automatic logic [31:0] add(input int rd, input int rs1, input int rs2);
        return {7'd0, 5'(rs2), 5'(rs1), rv_isa_pkg::f3_add, 5'(rd), rv_isa_pkg::opc_op};
    endfunction

    function automatic logic [31:0] lw(input int rd, input int rs1, input int imm);
        return {12'(imm), 5'(rs1), rv_isa_pkg::f3_word, 5'(rd), rv_isa_pkg::opc_load};
    endfunction

    function automatic logic [31:0] sw(input int rs2, input int rs1, input int imm);
        return {7'(imm >> 5), 5'(rs2), 5'(rs1), rv_isa_pkg::f3_word, 5'(imm),
                rv_isa_pkg::opc_store};
    endfunction

    // one instruction at a time, writeback forwarding makes the pipeline equivalent
    function automatic store_list_t ref_run(input logic [31:0] words [16]);
        logic [31:0] regs [32];
        logic [31:0] dmem [16];
        store_list_t stores;
        logic [31:0] w;
        logic [31:0] imm_i;
        logic [31:0] imm_s;
        logic [31:0] addr;
        logic [6:0]  opc;
        logic [2:0]  f3;
        for (int r = 0; r < 32; r++) regs[r] = '0;
        for (int m = 0; m < 16; m++) dmem[m] = '0;
        for (int pc = 0; pc < 16; pc++) begin
            w     = words[pc];
            opc   = w[6:0];
            f3    = w[14:12];
            imm_i = {{20{w[31]}}, w[31:20]};
            imm_s = {{20{w[31]}}, w[31:25], w[11:7]};
            if (opc == rv_isa_pkg::opc_op_imm && f3 == rv_isa_pkg::f3_add) begin
                regs[w[11:7]] = regs[w[19:15]] + imm_i;
            end else if (opc == rv_isa_pkg::opc_op && f3 == rv_isa_pkg::f3_add
                         && w[31:25] == 7'd0) begin
                regs[w[11:7]] = regs[w[19:15]] + regs[w[24:20]];
            end else if (opc == rv_isa_pkg::opc_load && f3 == rv_isa_pkg::f3_word) begin
                addr = regs[w[19:15]] + imm_i;
                regs[w[11:7]] = dmem[addr[5:2]];
            end else if (opc == rv_isa_pkg::opc_store && f3 == rv_isa_pkg::f3_word) begin
                addr = regs[w[19:15]] + imm_s;
                dmem[addr[5:2]] = regs[w[24:20]];
                stores.push_back({addr, regs[w[24:20]]});
            end
            regs[0] = '0;  // x0 hardwired
        end
        return stores;
    endfunction

    task automatic make_random_program();
        logic [31:0] rnd;
        int rd;
        int rs1;
        int rs2;
        int imm;
        for (int i = 0; i < 16; i++) begin
            rnd = $urandom;
            rd  = $urandom % 8;
            rs1 = $urandom % 8;
            rs2 = $urandom % 8;
            imm = int'($urandom % 16) - 8;
            case ($urandom % 9)
                0, 1: prog[i] = addi(rd, rs1, imm);
                2, 3: prog[i] = add(rd, rs1, rs2);
                4: prog[i] = lw(rd, 0, 4 * ($urandom % 16));
                5: prog[i] = sw(rs2, 0, 4 * ($urandom % 16));
                6: prog[i] = {rnd[31:7], 7'b1100011};  // branch, unsupported
                7: prog[i] = {7'b0100000, 5'(rs2), 5'(rs1), 3'b000, 5'(rd), rv_isa_pkg::opc_op};
                default: prog[i] = {12'(imm), 5'(rs1), 3'b000, 5'(rd), rv_isa_pkg::opc_load};
            endcase
        end
    endtask

    task automatic apply_reset();
        @(posedge clk);
        #drive_delay;
        arst_n = 1'b0;
        run    = 1'b0;
        repeat (reset_cycles) @(posedge clk);
        #drive_delay;
        arst_n = 1'b1;
    endtask

    task automatic load_program();
        for (int i = 0; i < 16; i++) begin
            @(posedge clk);
            #drive_delay;
            prog_we   = 1'b1;
            prog_addr = 4'(i);
            prog_data = prog[i];
        end
        @(posedge clk);
        #drive_delay;
        prog_we = 1'b0;
    endtask

    task automatic report_test(input string name, input int errs_before);
        if (checker_i.error_count == errs_before) begin
            tests_passed++;
            $display("%s: ok", name);
        end else begin
            tests_failed++;
            $display("%s: FAILED with %0d errors", name, checker_i.error_count - errs_before);
        end
    endtask

    task automatic test_reset();
        int errs_before;
        errs_before = checker_i.error_count;
        apply_reset();  // checker looks at the outputs during reset
        @(posedge clk);
        #drive_delay;
        checker_i.check_idle();
        report_test("reset", errs_before);
    endtask

    task automatic run_program(input string name, input logic exp_div,
                               input lockstep_pkg::diverge_cause_t exp_cause, input logic inject);
        store_list_t exp_stores;
        int errs_before;
        int waited;
        apply_reset();
        errs_before = checker_i.error_count;
        checker_i.start_test();
        load_program();
        exp_stores = ref_run(prog);
        foreach (exp_stores[i]) checker_i.expect_store(exp_stores[i].addr, exp_stores[i].data);
        if (inject) begin
            @(posedge clk);
            #drive_delay;
            inject_err = 1'b1;
            inject_reg = 5'd5;
            @(posedge clk);
            #drive_delay;
            inject_err = 1'b0;
        end
        @(posedge clk);
        #drive_delay;
        run    = 1'b1;
        waited = 0;
        while (!halted && waited < run_cycles + margin_cycles) begin
            @(negedge clk);
            waited++;
        end
        repeat (2) @(posedge clk);
        #drive_delay;
        run = 1'b0;
        @(posedge clk);
        #drive_delay;
        checker_i.finish_test(exp_div, exp_cause);
        report_test(name, errs_before);
    endtask

    // safety net against a hung run
    initial begin
        while (cycle_count < cycle_limit) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout after %0d cycles, a test never finished", cycle_limit);
        $display("Test failed");
        $finish;
    end

    initial begin
        void'($urandom(32'h9f0e_e303));
        arst_n     = 1'b0;
        prog_we    = 1'b0;
        prog_addr  = '0;
        prog_data  = '0;
        run        = 1'b0;
        inject_err = 1'b0;
        inject_reg = '0;

        test_reset();

        prog = '{addi(1, 0, 5), addi(2, 1, 3), add(3, 1, 2), add(3, 3, 3),
                 addi(4, 3, -1), sw(4, 0, 0), sw(3, 0, 4), add(5, 4, 2),
                 addi(0, 5, 9), sw(5, 0, 8), sw(0, 0, 12), add(6, 5, 5),
                 sw(6, 0, 16), nop, nop, sw(1, 0, 60)};
        run_program("alu chains", 1'b0, lockstep_pkg::cause_none, 1'b0);

        // word 8 and 60 were written by the previous program, reset must clear them
        prog = '{addi(1, 0, 20), addi(2, 0, -3), sw(2, 1, 0), lw(3, 1, 0),
                 add(4, 3, 3), sw(4, 1, 4), lw(5, 0, 8), addi(5, 5, 1),
                 sw(5, 0, 12), lw(6, 0, 60), sw(6, 1, 28), lw(7, 1, 4),
                 sw(7, 0, 32), nop, nop, nop};
        run_program("load forwarding", 1'b0, lockstep_pkg::cause_none, 1'b0);

        prog = '{addi(1, 0, 12), addi(2, 1, -4), sw(2, 1, 0), addi(6, 5, 0),
                 add(7, 6, 2), sw(7, 0, 4), sw(6, 0, 8), nop,
                 nop, nop, nop, nop, nop, nop, nop, nop};
        run_program("injected error", 1'b1, lockstep_pkg::cause_wb, 1'b1);

        make_random_program();
        run_program("random mix", 1'b0, lockstep_pkg::cause_none, 1'b0);

        total_errors = checker_i.error_count + dut_i.cmp_i.sva_i.fail_count;
        $display("tests passed %0d, failed %0d, errors %0d", tests_passed, tests_failed,
                 total_errors);
        if (tests_failed == 0 && total_errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule
